//--- src/adpcmb_defs.svh
// Shared sizes for the ADPCM-B playback unit
// Changing AW also changes the nibble address width (AW+1)
`ifndef ADPCMB_DEFS_SVH
`define ADPCMB_DEFS_SVH

// Sample memory byte address width
`define ADPCMB_AW 16

// Delta-N phase accumulator width
`define ADPCMB_ACC_W 16

// Adaptive step limits
`define ADPCMB_STEP_MIN 127
`define ADPCMB_STEP_MAX 24576

// Channels at the top level
`define ADPCMB_NCH 2
`endif

//--- src/adpcmb_pkg.sv
// Types and tables for the ADPCM-B channels
// Step multipliers are in 1/64 units, indexed by nibble magnitude
`include "adpcmb_defs.svh"

package adpcmb_pkg;

    // Signed 16-bit PCM sample
    typedef logic signed [15:0] pcm_t;

    // Per-channel playback setup
    typedef struct packed {
        logic [`ADPCMB_AW-1:0]    start;    // First byte
        logic [`ADPCMB_AW-1:0]    stop;     // Last byte, inclusive
        logic [`ADPCMB_ACC_W-1:0] delta_n;  // Rate, added per tick
        logic [7:0]               tl;       // Gain, 255 is near unity
        logic [1:0]               lr;       // Bit 1 left, bit 0 right
        logic                     rep;      // Loop back to start
    } chan_cfg_t;

    // Step scale per magnitude
    localparam logic [0:7][7:0] step_mult = '{
        8'd57,
        8'd57,
        8'd57,
        8'd57,
        8'd77,
        8'd102,
        8'd128,
        8'd153
    };

endpackage

//--- src/wb_rd_if.sv
// Read-only Wishbone classic link, byte data
// Master holds cyc/stb/adr until ack; no write or select lines
`include "adpcmb_defs.svh"

interface wb_rd_if;

    logic                  cyc;    // Cycle in progress
    logic                  stb;    // Strobe, valid address
    logic [`ADPCMB_AW-1:0] adr;    // Byte address
    logic [7:0]            dat_r;  // Read data, valid with ack
    logic                  ack;    // Transfer done

    modport master (
        output cyc, stb, adr,
        input  dat_r, ack
    );

    modport slave (
        input  cyc, stb, adr,
        output dat_r, ack
    );

endinterface

//--- src/adpcmb_addr_cnt.sv
// Delta-N rate and nibble address for one channel
// A nibble waits for byte_ready, so a late fetch stalls but never skips
`include "adpcmb_defs.svh"

module adpcmb_addr_cnt (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  tick,
    input  logic                  key_on,
    input  adpcmb_pkg::chan_cfg_t cfg,
    input  logic                  clr_flag,
    input  logic                  byte_ready,
    output logic [`ADPCMB_AW:0]   nib_addr,
    output logic                  adv,
    output logic                  on,
    output logic                  flag
);

    logic                     key_q;     // Last key_on
    logic                     key_rise;
    logic                     pend;      // Nibble owed to the decoder
    logic [`ADPCMB_ACC_W-1:0] acc;       // Phase accumulator
    logic [`ADPCMB_ACC_W:0]   acc_sum;   // Top bit is the carry
    logic                     last_nib;  // Low nibble of stop byte

    assign key_rise = key_on & ~key_q;
    assign acc_sum  = {1'b0, acc} + {1'b0, cfg.delta_n};
    assign adv      = on & pend & byte_ready;  // Consume once byte is held
    assign last_nib = (nib_addr == {cfg.stop, 1'b1});

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key_q    <= 1'b0;
            acc      <= '0;
            pend     <= 1'b0;
            nib_addr <= '0;
            on       <= 1'b0;
            flag     <= 1'b0;
        end else begin
            key_q <= key_on;
            if (clr_flag) flag <= 1'b0;
            if (key_rise) begin
                acc      <= '0;
                pend     <= 1'b0;
                nib_addr <= {cfg.start, 1'b0};  // High nibble of start byte
                on       <= 1'b1;
                flag     <= 1'b0;
            end else if (!key_on) begin
                on   <= 1'b0;                   // Key off stops playback
                pend <= 1'b0;
            end else if (on) begin
                if (tick) acc <= acc_sum[`ADPCMB_ACC_W-1:0];
                pend <= (pend & ~adv) | (tick & acc_sum[`ADPCMB_ACC_W]);
                if (adv) begin
                    if (!last_nib) begin
                        nib_addr <= nib_addr + 1'b1;
                    end else if (cfg.rep) begin
                        nib_addr <= {cfg.start, 1'b0};  // Loop
                    end else begin
                        on   <= 1'b0;
                        pend <= 1'b0;
                        flag <= 1'b1;           // Wins over clr_flag
                    end
                end
            end
        end
    end

endmodule

//--- src/adpcmb_decoder.sv
// ADPCM-B adaptive step decoder, one nibble per adv
// pcm saturates at 16 bits; step stays within 127..24576
`include "adpcmb_defs.svh"

module adpcmb_decoder (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             init,
    input  logic             adv,
    input  logic [3:0]       nibble,
    output adpcmb_pkg::pcm_t pcm
);
    import adpcmb_pkg::*;

    logic [15:0]        step;       // Current adaptive step
    logic [2:0]         mag;        // Nibble magnitude
    logic [18:0]        diff_full;  // (2m+1) * step
    logic signed [17:0] diff;       // Divided by 8
    logic signed [17:0] sum;        // Before clamping
    logic [23:0]        step_full;  // step * mult
    logic [17:0]        step_raw;   // Divided by 64
    pcm_t               pcm_nxt;
    logic [15:0]        step_nxt;

    assign mag       = nibble[2:0];
    assign diff_full = 19'({mag, 1'b1}) * 19'(step);
    assign diff      = $signed({2'b00, diff_full[18:3]});
    assign sum       = nibble[3] ? 18'(pcm) - diff : 18'(pcm) + diff;  // Bit 3 is sign
    assign step_full = step * 24'(step_mult[mag]);
    assign step_raw  = step_full[23:6];

    always_comb begin
        if (sum > 18'sd32767) pcm_nxt = 16'sh7fff;        // Clip high
        else if (sum < -18'sd32768) pcm_nxt = 16'sh8000;  // Clip low
        else pcm_nxt = sum[15:0];
        if (step_raw < 18'(`ADPCMB_STEP_MIN)) step_nxt = 16'(`ADPCMB_STEP_MIN);
        else if (step_raw > 18'(`ADPCMB_STEP_MAX)) step_nxt = 16'(`ADPCMB_STEP_MAX);
        else step_nxt = step_raw[15:0];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pcm  <= '0;
            step <= 16'(`ADPCMB_STEP_MIN);
        end else if (init) begin
            pcm  <= '0;                        // Fresh start on key on
            step <= 16'(`ADPCMB_STEP_MIN);
        end else if (adv) begin
            pcm  <= pcm_nxt;
            step <= step_nxt;
        end
    end

endmodule

//--- src/adpcmb_chan.sv
// One ADPCM-B channel with its own Wishbone read master
// Outputs change only on tick; key_on is a level, its rise restarts
`include "adpcmb_defs.svh"

module adpcmb_chan (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  tick,
    input  logic                  key_on,
    input  adpcmb_pkg::chan_cfg_t cfg,
    input  logic                  clr_flag,
    wb_rd_if.master               wb,
    output logic                  flag,
    output adpcmb_pkg::pcm_t      out_l,
    output adpcmb_pkg::pcm_t      out_r
);
    import adpcmb_pkg::*;

    typedef enum logic {F_IDLE, F_REQ} fetch_t;

    fetch_t                state;
    logic [`ADPCMB_AW:0]   nib_addr;
    logic                  adv;
    logic                  on;
    logic                  key_q;
    logic                  init;        // Key on rising edge
    logic                  vld;         // byte_q holds byte_adr
    logic                  byte_ready;  // Held byte matches nib_addr
    logic [`ADPCMB_AW-1:0] fetch_adr;
    logic [`ADPCMB_AW-1:0] byte_adr;
    logic [7:0]            byte_q;
    logic [3:0]            nibble;
    pcm_t                  pcm;
    logic signed [24:0]    gain_full;   // pcm * tl

    assign init       = key_on & ~key_q;
    assign byte_ready = vld && (byte_adr == nib_addr[`ADPCMB_AW:1]);
    assign nibble     = nib_addr[0] ? byte_q[3:0] : byte_q[7:4];  // High first
    assign gain_full  = pcm * $signed({1'b0, cfg.tl});

    assign wb.cyc = (state == F_REQ);
    assign wb.stb = (state == F_REQ);
    assign wb.adr = fetch_adr;

    adpcmb_addr_cnt u_cnt (
        .clk(clk), .rst_n(rst_n), .tick(tick), .key_on(key_on), .cfg(cfg),
        .clr_flag(clr_flag), .byte_ready(byte_ready),
        .nib_addr(nib_addr), .adv(adv), .on(on), .flag(flag)
    );

    adpcmb_decoder u_dec (
        .clk(clk), .rst_n(rst_n), .init(init), .adv(adv), .nibble(nibble), .pcm(pcm)
    );

    // Fetch FSM, one byte in flight
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= F_IDLE;
            vld       <= 1'b0;
            fetch_adr <= '0;
            key_q     <= 1'b0;
        end else begin
            key_q <= key_on;
            case (state)
                F_IDLE: if (on && !byte_ready && !init) begin
                    state     <= F_REQ;
                    fetch_adr <= nib_addr[`ADPCMB_AW:1];
                end
                F_REQ: if (wb.ack) begin
                    state <= F_IDLE;               // stb drops next cycle
                    vld   <= 1'b1;
                end
                default: state <= F_IDLE;
            endcase
            if (init) vld <= 1'b0;                 // Old byte is stale
        end
    end

    always_ff @(posedge clk) begin
        if (state == F_REQ && wb.ack) begin
            byte_q   <= wb.dat_r;
            byte_adr <= fetch_adr;
        end
    end

    // Gain floors toward minus infinity, pan per side
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_l <= '0;
            out_r <= '0;
        end else if (tick) begin
            out_l <= cfg.lr[1] ? gain_full[23:8] : '0;
            out_r <= cfg.lr[0] ? gain_full[23:8] : '0;
        end
    end

endmodule

//--- src/wb_rd_arbiter.sv
// Round-robin arbiter, two Wishbone read masters to one slave
// Grant changes only between cycles; paths are combinational
module wb_rd_arbiter (
    input  logic    clk,
    input  logic    rst_n,
    wb_rd_if.slave  m0,
    wb_rd_if.slave  m1,
    wb_rd_if.master s
);

    logic [1:0] req;     // Active requests
    logic       busy;    // Cycle held past its first clock
    logic       gnt;     // Master owning the held cycle
    logic       last;    // Master served last
    logic       pick;    // Choice while idle
    logic       sel;     // Master on the bus now
    logic [1:0] gnt_oh;  // One-hot grant

    assign req    = {m1.cyc & m1.stb, m0.cyc & m0.stb};
    assign pick   = (req == 2'b11) ? ~last : req[1];  // Tie goes to the other one
    assign sel    = busy ? gnt : pick;
    assign gnt_oh = (busy || req != 2'b00) ? (sel ? 2'b10 : 2'b01) : 2'b00;

    assign s.cyc  = sel ? m1.cyc : m0.cyc;
    assign s.stb  = sel ? m1.stb : m0.stb;
    assign s.adr  = sel ? m1.adr : m0.adr;

    assign m0.dat_r = s.dat_r;
    assign m1.dat_r = s.dat_r;
    assign m0.ack   = s.ack & gnt_oh[0];              // Only the owner sees ack
    assign m1.ack   = s.ack & gnt_oh[1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            gnt  <= 1'b0;
            last <= 1'b1;                              // m0 wins the first tie
        end else if (s.cyc && s.stb) begin
            if (s.ack) begin
                busy <= 1'b0;
                last <= sel;
            end else if (!busy) begin
                busy <= 1'b1;                          // Lock until ack
                gnt  <= sel;
            end
        end
    end

endmodule

//--- src/adpcmb_dual.sv
// Two-channel ADPCM-B player with a shared byte-wide sample memory port
// pcm_l/pcm_r update one clock after tick, saturated to 16 bits
`include "adpcmb_defs.svh"

module adpcmb_dual (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  tick,
    input  logic                  key_on0,
    input  logic                  key_on1,
    input  adpcmb_pkg::chan_cfg_t cfg0,
    input  adpcmb_pkg::chan_cfg_t cfg1,
    input  logic                  clr_flag0,
    input  logic                  clr_flag1,
    input  logic [7:0]            mem_dat,
    input  logic                  mem_ack,
    output logic                  mem_cyc,
    output logic                  mem_stb,
    output logic [`ADPCMB_AW-1:0] mem_adr,
    output logic                  flag0,
    output logic                  flag1,
    output adpcmb_pkg::pcm_t      pcm_l,
    output adpcmb_pkg::pcm_t      pcm_r
);
    import adpcmb_pkg::*;

    pcm_t               ch_l [`ADPCMB_NCH];  // Per-channel left
    pcm_t               ch_r [`ADPCMB_NCH];
    logic signed [16:0] sum_l;               // One guard bit for two channels
    logic signed [16:0] sum_r;
    logic               tick_q;              // Channel outputs settled

    wb_rd_if wb0 ();
    wb_rd_if wb1 ();
    wb_rd_if wbm ();

    assign mem_cyc   = wbm.cyc;
    assign mem_stb   = wbm.stb;
    assign mem_adr   = wbm.adr;
    assign wbm.dat_r = mem_dat;
    assign wbm.ack   = mem_ack;

    adpcmb_chan u_ch0 (
        .clk(clk), .rst_n(rst_n), .tick(tick), .key_on(key_on0), .cfg(cfg0),
        .clr_flag(clr_flag0), .wb(wb0), .flag(flag0), .out_l(ch_l[0]), .out_r(ch_r[0])
    );

    adpcmb_chan u_ch1 (
        .clk(clk), .rst_n(rst_n), .tick(tick), .key_on(key_on1), .cfg(cfg1),
        .clr_flag(clr_flag1), .wb(wb1), .flag(flag1), .out_l(ch_l[1]), .out_r(ch_r[1])
    );

    wb_rd_arbiter u_arb (.clk(clk), .rst_n(rst_n), .m0(wb0), .m1(wb1), .s(wbm));

    function automatic pcm_t sat16(input logic signed [16:0] v);
        if (v > 17'sd32767) return 16'sh7fff;
        if (v < -17'sd32768) return 16'sh8000;
        return v[15:0];
    endfunction

    always_comb begin
        sum_l = '0;
        sum_r = '0;
        for (int i = 0; i < `ADPCMB_NCH; i++) begin
            sum_l = sum_l + 17'(ch_l[i]);  // Sign extended
            sum_r = sum_r + 17'(ch_r[i]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tick_q <= 1'b0;
            pcm_l  <= '0;
            pcm_r  <= '0;
        end else begin
            tick_q <= tick;
            if (tick_q) begin
                pcm_l <= sat16(sum_l);
                pcm_r <= sat16(sum_r);
            end
        end
    end

endmodule

//--- testbench/adpcmb_sva.sv
// Arbiter bus checks, bound into every wb_rd_arbiter
// Sampled on clk and idle while rst_n is low
`include "adpcmb_defs.svh"

module adpcmb_sva (
    input logic                  clk,
    input logic                  rst_n,
    input logic [1:0]            req,
    input logic [1:0]            gnt_oh,
    input logic                  s_stb,
    input logic                  s_ack,
    input logic [`ADPCMB_AW-1:0] s_adr,
    input logic                  m0_ack,
    input logic                  m1_ack
);

    a_grant_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (s_stb && !s_ack) |=> $stable(gnt_oh))
        else $error("grant moved to the other master before ack");

    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (s_stb && !s_ack) |=> (s_stb && $stable(s_adr)))
        else $error("strobe or address moved before ack");

    a_ack_m0: assert property (@(posedge clk) disable iff (!rst_n) m0_ack |-> req[0])
        else $error("ack to master 0 without its strobe");

    a_ack_m1: assert property (@(posedge clk) disable iff (!rst_n) m1_ack |-> req[1])
        else $error("ack to master 1 without its strobe");

endmodule

bind wb_rd_arbiter adpcmb_sva u_sva (
    .clk(clk), .rst_n(rst_n), .req(req), .gnt_oh(gnt_oh), .s_stb(s.stb),
    .s_ack(s.ack), .s_adr(s.adr), .m0_ack(m0.ack), .m1_ack(m1.ack)
);

//--- testbench/adpcmb_tb.sv
// Directed tests for the two-channel ADPCM-B player
// Memory acks within 3 clocks, far inside the 64-clock tick period
`include "adpcmb_defs.svh"

module adpcmb_tb;
    import adpcmb_pkg::*;

    localparam int TICKS = 104;                // All tests together
    localparam int LIMIT = TICKS * 64 + 1000;  // Reset, key on and slack

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  tick;
    logic                  key_on [`ADPCMB_NCH];
    chan_cfg_t             cfg [`ADPCMB_NCH];
    logic                  clr_flag [`ADPCMB_NCH];
    logic [7:0]            mem_dat;
    logic                  mem_ack;
    logic                  mem_cyc;
    logic                  mem_stb;
    logic [`ADPCMB_AW-1:0] mem_adr;
    logic                  flag0;
    logic                  flag1;
    pcm_t                  pcm_l;
    pcm_t                  pcm_r;

    logic [7:0]            mem [0:65535];        // Sample memory
    logic [15:0]           lfsr_q = 16'd26800;
    logic [`ADPCMB_AW-1:0] addr_log [$];         // Acked read addresses
    bit                    mem_busy;
    int                    lat_left;
    int                    cycles = 0;
    bit                    sat_seen;             // Mix overflowed once

    // Reference channel state
    int          m_pcm [`ADPCMB_NCH];
    int          m_step [`ADPCMB_NCH];
    logic [15:0] m_acc [`ADPCMB_NCH];
    logic [16:0] m_nib [`ADPCMB_NCH];
    bit          m_on [`ADPCMB_NCH];
    bit          m_flag [`ADPCMB_NCH];
    int          m_out_l [`ADPCMB_NCH];
    int          m_out_r [`ADPCMB_NCH];

    adpcmb_dual dut_i (
        .clk(clk), .rst_n(rst_n), .tick(tick),
        .key_on0(key_on[0]), .key_on1(key_on[1]), .cfg0(cfg[0]), .cfg1(cfg[1]),
        .clr_flag0(clr_flag[0]), .clr_flag1(clr_flag[1]),
        .mem_dat(mem_dat), .mem_ack(mem_ack), .mem_cyc(mem_cyc), .mem_stb(mem_stb),
        .mem_adr(mem_adr), .flag0(flag0), .flag1(flag1), .pcm_l(pcm_l), .pcm_r(pcm_r)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout: the run went past its cycle budget");
            $display(">>> FAIL");
            $fatal(1, "timeout");
        end
    end

    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];  // x^16+x^14+x^13+x^11+1
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    // Memory slave, latency 1 to 3 clocks
    always @(posedge clk) begin
        int v;
        #2;
        if (mem_ack) begin
            mem_ack = 1'b0;
            mem_busy = 1'b0;
        end else if (mem_cyc && mem_stb) begin
            if (!mem_busy) begin
                v = 2 * int'(lfsr_bit());
                v = v + int'(lfsr_bit());
                lat_left = 1 + v % 3;
                mem_busy = 1'b1;
            end
            lat_left = lat_left - 1;
            if (lat_left == 0) begin
                mem_dat = mem[mem_adr];
                mem_ack = 1'b1;
                addr_log.push_back(mem_adr);
            end
        end
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_pcm(input pcm_t got, input pcm_t exp, input string what);
        if (got !== exp)
            fail_now($sformatf("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp));
    endtask

    task automatic check_flag(input bit got, input bit exp, input string what);
        if (got !== exp)
            fail_now($sformatf("Mismatch at %0t: %s got %0b expected %0b", $time, what, got, exp));
    endtask

    task automatic check_addr(input logic [15:0] got, input logic [15:0] exp, input string what);
        if (got !== exp)
            fail_now($sformatf("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
    endtask

    function automatic int clamp(input int v, input int lo, input int hi);
        if (v < lo) return lo;
        if (v > hi) return hi;
        return v;
    endfunction

    function automatic int step_scale(input int m);
        case (m)
            4: return 77;
            5: return 102;
            6: return 128;
            7: return 153;
            default: return 57;
        endcase
    endfunction

    function automatic chan_cfg_t make_cfg(input logic [15:0] start, input logic [15:0] stop,
                                           input logic [15:0] dn, input logic [7:0] tl,
                                           input logic [1:0] lr, input logic rep);
        chan_cfg_t c;
        c.start = start;
        c.stop = stop;
        c.delta_n = dn;
        c.tl = tl;
        c.lr = lr;
        c.rep = rep;
        return c;
    endfunction

    task automatic fill(input logic [15:0] adr, input int n, input logic [7:0] b);
        for (int i = 0; i < n; i++) mem[adr + 16'(i)] = b;
    endtask

    // Decode one nibble, high nibble first, then step the address
    task automatic consume(input int ch);
        logic [7:0] b;
        logic [3:0] n;
        int         m;
        int         diff;
        b = mem[m_nib[ch][16:1]];
        n = m_nib[ch][0] ? b[3:0] : b[7:4];
        m = int'(n[2:0]);
        diff = ((2 * m + 1) * m_step[ch]) / 8;
        m_pcm[ch] = clamp(n[3] ? m_pcm[ch] - diff : m_pcm[ch] + diff, -32768, 32767);
        m_step[ch] = clamp(m_step[ch] * step_scale(m) / 64, `ADPCMB_STEP_MIN, `ADPCMB_STEP_MAX);
        if (m_nib[ch] == {cfg[ch].stop, 1'b1}) begin
            if (cfg[ch].rep) begin
                m_nib[ch] = {cfg[ch].start, 1'b0};
            end else begin
                m_on[ch] = 1'b0;
                m_flag[ch] = 1'b1;
            end
        end else begin
            m_nib[ch] = m_nib[ch] + 17'd1;
        end
    endtask

    // One tick period, then compare the mixed output with the model
    task automatic tick_check();
        logic [16:0] sum;
        int          exp_l;
        int          exp_r;
        repeat (62) @(posedge clk);
        #2 tick = 1'b1;
        @(posedge clk);
        #2 tick = 1'b0;
        @(posedge clk);
        #2;
        exp_l = 0;
        exp_r = 0;
        for (int ch = 0; ch < `ADPCMB_NCH; ch++) begin
            m_out_l[ch] = cfg[ch].lr[1] ? (m_pcm[ch] * int'(cfg[ch].tl)) >>> 8 : 0;
            m_out_r[ch] = cfg[ch].lr[0] ? (m_pcm[ch] * int'(cfg[ch].tl)) >>> 8 : 0;
            exp_l = exp_l + m_out_l[ch];
            exp_r = exp_r + m_out_r[ch];
            if (m_on[ch]) begin
                sum = {1'b0, m_acc[ch]} + {1'b0, cfg[ch].delta_n};
                m_acc[ch] = sum[15:0];
                if (sum[16]) consume(ch);                // Carry takes a nibble
            end
        end
        if (exp_l > 32767 || exp_r > 32767) sat_seen = 1'b1;
        check_pcm(pcm_l, pcm_t'(clamp(exp_l, -32768, 32767)), "pcm_l");
        check_pcm(pcm_r, pcm_t'(clamp(exp_r, -32768, 32767)), "pcm_r");
        check_flag(flag0, m_flag[0], "flag0");
        check_flag(flag1, m_flag[1], "flag1");
    endtask

    task automatic start_chan(input int ch, input chan_cfg_t c);
        @(posedge clk);
        #2 key_on[ch] = 1'b0;
        @(posedge clk);
        #2;
        cfg[ch] = c;
        key_on[ch] = 1'b1;                               // Rise restarts the stream
        m_pcm[ch] = 0;
        m_step[ch] = `ADPCMB_STEP_MIN;
        m_acc[ch] = '0;
        m_nib[ch] = {c.start, 1'b0};
        m_on[ch] = 1'b1;
        m_flag[ch] = 1'b0;
    endtask

    // Bus idle, flags low and mix silent out of reset
    task automatic test_reset();
        check_flag(mem_cyc, 1'b0, "mem_cyc after reset");
        check_flag(mem_stb, 1'b0, "mem_stb after reset");
        check_flag(flag0, 1'b0, "flag0 after reset");
        check_flag(flag1, 1'b0, "flag1 after reset");
        check_pcm(pcm_l, '0, "pcm_l after reset");
        check_pcm(pcm_r, '0, "pcm_r after reset");
    endtask

    task automatic test_decode();
        fill(16'h0100, 6, 8'h77);                        // Max steps up to the clamp
        fill(16'h0106, 4, 8'hff);
        fill(16'h010a, 6, 8'h3b);
        start_chan(0, make_cfg(16'h0100, 16'h010f, 16'hffff, 8'd255, 2'b11, 1'b0));
        repeat (20) tick_check();
    endtask

    task automatic test_rate();
        addr_log.delete();
        start_chan(0, make_cfg(16'h0200, 16'h020f, 16'h8000, 8'd128, 2'b10, 1'b0));
        repeat (16) tick_check();
        if (addr_log.size() < 4) fail_now("Rate test saw fewer than four memory reads");
        for (int i = 0; i < 4; i++) check_addr(addr_log[i], 16'h0200 + 16'(i), "read address");
    endtask

    task automatic test_end();
        fill(16'h0300, 1, 8'h52);
        fill(16'h0301, 1, 8'h9c);
        start_chan(0, make_cfg(16'h0300, 16'h0301, 16'hffff, 8'd255, 2'b11, 1'b0));
        repeat (8) tick_check();
        check_flag(flag0, 1'b1, "flag0 after stop byte");
        check_flag(mem_cyc, 1'b0, "mem_cyc with channel stopped");
        @(posedge clk);
        #2 clr_flag[0] = 1'b1;
        @(posedge clk);
        #2 clr_flag[0] = 1'b0;
        m_flag[0] = 1'b0;
        check_flag(flag0, 1'b0, "flag0 after clear");
        start_chan(0, make_cfg(16'h0300, 16'h0301, 16'hffff, 8'd255, 2'b11, 1'b1));
        repeat (12) tick_check();                        // Wraps back to start twice
    endtask

    task automatic test_gain();
        logic [7:0] tls [4];
        logic [1:0] lrs [4];
        tls = '{8'd64, 8'd200, 8'd0, 8'd255};
        lrs = '{2'b10, 2'b01, 2'b11, 2'b00};
        for (int i = 0; i < 4; i++) begin
            start_chan(0, make_cfg(16'h0400, 16'h041f, 16'hffff, tls[i], lrs[i], 1'b0));
            repeat (6) tick_check();
        end
    endtask

    task automatic test_dual();
        fill(16'h0500, 12, 8'h77);
        fill(16'h0600, 12, 8'h76);
        sat_seen = 1'b0;
        start_chan(0, make_cfg(16'h0500, 16'h05ff, 16'hffff, 8'd255, 2'b11, 1'b0));
        start_chan(1, make_cfg(16'h0600, 16'h06ff, 16'hc000, 8'd255, 2'b11, 1'b1));
        repeat (24) tick_check();
        if (!sat_seen) fail_now("Two-channel test never drove the mix past full scale");
    endtask

    initial begin
        rst_n = 1'b0;
        tick = 1'b0;
        mem_dat = '0;
        mem_ack = 1'b0;
        mem_busy = 1'b0;
        lat_left = 0;
        sat_seen = 1'b0;
        for (int ch = 0; ch < `ADPCMB_NCH; ch++) begin
            key_on[ch] = 1'b0;
            cfg[ch] = '0;
            clr_flag[ch] = 1'b0;
            m_pcm[ch] = 0;
            m_step[ch] = `ADPCMB_STEP_MIN;
            m_acc[ch] = '0;
            m_nib[ch] = '0;
            m_on[ch] = 1'b0;
            m_flag[ch] = 1'b0;
            m_out_l[ch] = 0;
            m_out_r[ch] = 0;
        end
        for (int a = 0; a < 65536; a++) mem[a] = 8'(a) ^ 8'((a >> 8) * 5) ^ 8'h3c;
        repeat (10) @(posedge clk);
        #2 rst_n = 1'b1;
        test_reset();
        test_decode();
        test_rate();
        test_end();
        test_gain();
        test_dual();
        $display(">>> PASS");
        $finish;
    end

endmodule

//--- build.f
+incdir+src
src/adpcmb_pkg.sv
src/wb_rd_if.sv
src/adpcmb_addr_cnt.sv
src/adpcmb_decoder.sv
src/adpcmb_chan.sv
src/wb_rd_arbiter.sv
src/adpcmb_dual.sv
testbench/adpcmb_sva.sv
testbench/adpcmb_tb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator and run; status follows the testbench verdict
verilator --binary --assert -f build.f --top-module adpcmb_tb -o adpcmb_sim \
    && ./obj_dir/adpcmb_sim | grep -x '>>> PASS' \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
